//--- pool.f
+incdir+rtl
rtl/pool_pkg.sv
rtl/pool_arbiter.sv
rtl/map_sipo.sv
rtl/pool_max_unit.sv
rtl/pool_core.sv
rtl/pool_top.sv
test/pool_glb_model.sv
test/pool_tb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the pooling engine testbench
# The verdict comes from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module pool_tb -f pool.f -o pool_sim \
    && ./obj_dir/pool_sim > sim.log 2>&1 \
    || echo "Build or simulation run failed"
[ -f sim.log ] && cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log 2>/dev/null \
    && echo "Result: passed" \
    || { echo "Result: failed"; exit 1; }

//--- test/pool_tb.sv
// ==============================
// Pooling engine testbench
// Table-driven runs on both cores
// Every write checked against a reference max
// ==============================
`include "pool_settings.svh"

module pool_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CORES    = `POOL_CORES;
    localparam int NRUN     = 3;
    localparam int PER_WORD = `POOL_SRAM_W / `POOL_IDX_W;
    localparam int CFG_TMO  = 20;
    localparam int RUN_TMO  = 20000;

    // One core setup within a run
    typedef struct packed {
        pool_pkg::idx_t points;
        pool_pkg::nbr_t k;
        pool_pkg::chn_t chn;
        pool_pkg::idx_t base;
    } cfg_row_t;

    logic                clk;
    logic                rst_n;
    logic [CORES-1:0]    cfg_vld;
    pool_pkg::idx_t      cfg_points   [CORES];
    pool_pkg::nbr_t      cfg_k        [CORES];
    pool_pkg::chn_t      cfg_chn      [CORES];
    pool_pkg::idx_t      cfg_out_base [CORES];
    logic [CORES-1:0]    cfg_rdy;
    logic                map_rd_addr_vld;
    pool_pkg::idx_t      map_rd_addr;
    logic                map_rd_addr_rdy;
    logic                map_rd_dat_vld;
    pool_pkg::map_word_t map_rd_dat;
    logic                map_rd_dat_rdy;
    logic [CORES-1:0]    ofm_rd_addr_vld;
    pool_pkg::idx_t      ofm_rd_addr [CORES];
    logic [CORES-1:0]    ofm_rd_addr_rdy;
    logic [CORES-1:0]    ofm_rd_dat_vld;
    pool_pkg::lanes_t    ofm_rd_dat  [CORES];
    logic [CORES-1:0]    ofm_rd_dat_rdy;
    logic                ofm_wr_vld;
    pool_pkg::idx_t      ofm_wr_addr;
    pool_pkg::lanes_t    ofm_wr_dat;
    logic                ofm_wr_rdy;

    cfg_row_t            stim [NRUN][CORES];
    int                  run_idx;
    logic [CORES-1:0]    busy_core;
    logic                stalled;
    // Write bookkeeping, owned by the write monitor
    int unsigned         seen   [NRUN][1024];
    int                  wr_cnt [NRUN][CORES];
    int                  wr_errs    = 0;
    int                  proto_errs = 0;
    int                  cnt_errs   = 0;
    int                  flag_errs  = 0;
    int                  tmo_errs   = 0;

    pool_top dut_i (.*);

    pool_glb_model glb_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // points, K, channels, out_base
    task automatic load_table();
        stim[0][0] = '{16'd4, 4'd1, 8'd8,  16'd0};
        stim[0][1] = '{16'd3, 4'd1, 8'd4,  16'd100};
        stim[1][0] = '{16'd5, 4'd8, 8'd32, 16'd200};
        stim[1][1] = '{16'd6, 4'd3, 8'd16, 16'd300};
        stim[2][0] = '{16'd3, 4'd5, 8'd12, 16'd400};
        stim[2][1] = '{16'd2, 4'd8, 8'd24, 16'd450};
    endtask

    // Output words of one core in the current run
    function automatic int writes_of(input int c);
        return int'(stim[run_idx][c].points) * (int'(stim[run_idx][c].chn) / `POOL_LANES);
    endfunction

    // Core whose output range holds the address, -1 if none
    function automatic int owner_of(input pool_pkg::idx_t addr);
        int hit;
        hit = -1;
        for (int c = 0; c < CORES; c++) begin
            if (int'(addr) >= int'(stim[run_idx][c].base)
                && int'(addr) < int'(stim[run_idx][c].base) + writes_of(c)) begin
                hit = c;
            end
        end
        return hit;
    endfunction

    // Entry n of the neighbor list of point p
    function automatic pool_pkg::idx_t nbr_index(input int p, input int n);
        pool_pkg::map_word_t w;
        w = glb_i.map_mem[p * `POOL_MAP_WORDS + n / PER_WORD];
        return w[(n % PER_WORD) * `POOL_IDX_W +: `POOL_IDX_W];
    endfunction

    // Lane-wise max over the first K neighbors
    function automatic pool_pkg::lanes_t expected_max(input pool_pkg::idx_t addr);
        cfg_row_t         row;
        int               grp;
        int               off;
        int               p;
        int               g;
        pool_pkg::lanes_t feat;
        pool_pkg::lanes_t acc;
        row = stim[run_idx][owner_of(addr)];
        grp = int'(row.chn) / `POOL_LANES;
        off = int'(addr) - int'(row.base);
        p   = off / grp;
        g   = off % grp;
        acc = '0;
        for (int n = 0; n < int'(row.k); n++) begin
            feat = glb_i.feat_mem[grp * int'(nbr_index(p, n)) + g];
            for (int l = 0; l < `POOL_LANES; l++) begin
                if (n == 0 || feat[l] > acc[l]) begin
                    acc[l] = feat[l];
                end
            end
        end
        return acc;
    endfunction

    task automatic check_wr(input pool_pkg::idx_t addr, input pool_pkg::lanes_t dat);
        pool_pkg::lanes_t exp;
        exp = expected_max(addr);
        if (dat !== exp) begin
            $display("[FAIL] ofm_wr_dat at 0x%h: got 0x%h, expected 0x%h", addr, dat, exp);
            wr_errs++;
        end
    endtask

    task automatic check_count(input int c, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] write count of core %0d: got 0x%h, expected 0x%h", c, got, exp);
            cnt_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            flag_errs++;
        end
    endtask

    task automatic record_write(input pool_pkg::idx_t addr, input pool_pkg::lanes_t dat);
        int c;
        c = owner_of(addr);
        if (c < 0) begin
            $display("Write to address 0x%h lies outside every output range", addr);
            wr_errs++;
        end else begin
            if (seen[run_idx][addr] != 0) begin
                $display("Address 0x%h was written more than once", addr);
                wr_errs++;
            end
            seen[run_idx][addr]++;
            wr_cnt[run_idx][c]++;
            check_wr(addr, dat);
        end
    endtask

    // ==============================
    // Write monitor
    // ==============================
    always @(negedge clk) begin
        if (rst_n) begin
            // cfg_rdy must stay low until the core's last write
            for (int c = 0; c < CORES; c++) begin
                if (busy_core[c] && cfg_rdy[c] && wr_cnt[run_idx][c] < writes_of(c)) begin
                    $display("cfg_rdy of core %0d rose before its last write", c);
                    proto_errs++;
                end
            end
            if (ofm_wr_vld && ofm_wr_rdy) begin
                record_write(ofm_wr_addr, ofm_wr_dat);
            end
        end
    end

    // Both cores configured together
    task automatic apply_run(input int r);
        logic [CORES-1:0] pend;
        logic [CORES-1:0] hs;
        int               tries;
        @(posedge clk);
        run_idx = r;
        for (int c = 0; c < CORES; c++) begin
            cfg_vld[c]      <= 1'b1;
            cfg_points[c]   <= stim[r][c].points;
            cfg_k[c]        <= stim[r][c].k;
            cfg_chn[c]      <= stim[r][c].chn;
            cfg_out_base[c] <= stim[r][c].base;
        end
        pend  = '1;
        tries = 0;
        while (pend != '0 && tries < CFG_TMO) begin
            @(negedge clk);
            // Taken on the coming rising edge
            hs = cfg_vld & cfg_rdy;
            @(posedge clk);
            cfg_vld   <= cfg_vld & ~hs;
            busy_core = busy_core | hs;
            pend      = pend & ~hs;
            tries++;
        end
        if (pend != '0) begin
            $display("Timeout: configuration of run %0d was not accepted", r);
            tmo_errs++;
            stalled = 1'b1;
        end
    endtask

    // Until every core has written its words and raised cfg_rdy
    task automatic wait_run(input int r);
        logic all_done;
        int   tries;
        all_done = 1'b0;
        tries    = 0;
        while (!all_done && tries < RUN_TMO) begin
            @(negedge clk);
            all_done = 1'b1;
            for (int c = 0; c < CORES; c++) begin
                if (wr_cnt[r][c] < writes_of(c) || !cfg_rdy[c]) begin
                    all_done = 1'b0;
                end
            end
            tries++;
        end
        if (!all_done) begin
            $display("Timeout: run %0d did not finish its writes", r);
            tmo_errs++;
            stalled = 1'b1;
        end
        @(posedge clk);
        for (int c = 0; c < CORES; c++) begin
            check_count(c, wr_cnt[r][c], writes_of(c));
        end
        busy_core = '0;
    endtask

    initial begin
        int total_errs;
        rst_n     = 1'b0;
        cfg_vld   = '0;
        for (int c = 0; c < CORES; c++) begin
            cfg_points[c]   = '0;
            cfg_k[c]        = '0;
            cfg_chn[c]      = '0;
            cfg_out_base[c] = '0;
        end
        run_idx   = 0;
        busy_core = '0;
        stalled   = 1'b0;
        load_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Idle outputs after reset
        @(negedge clk);
        check_flag("ofm_wr_vld", ofm_wr_vld, 1'b0);
        check_flag("map_rd_addr_vld", map_rd_addr_vld, 1'b0);
        for (int c = 0; c < CORES; c++) begin
            check_flag($sformatf("ofm_rd_addr_vld[%0d]", c), ofm_rd_addr_vld[c], 1'b0);
            check_flag($sformatf("cfg_rdy[%0d]", c), cfg_rdy[c], 1'b1);
        end

        for (int r = 0; r < NRUN; r++) begin
            if (!stalled) begin
                apply_run(r);
            end
            if (!stalled) begin
                wait_run(r);
            end
        end

        total_errs = wr_errs + proto_errs + cnt_errs + flag_errs + tmo_errs;
        $display("Errors: write %0d, protocol %0d, count %0d, flag %0d, timeout %0d",
                 wr_errs, proto_errs, cnt_errs, flag_errs, tmo_errs);
        if (total_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end
endmodule

//--- test/pool_glb_model.sv
// ==============================
// Global buffer model
// Map and feature tables, random read latency
// Random write back-pressure
// ==============================
`include "pool_settings.svh"

module pool_glb_model (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   map_rd_addr_vld,
    input  pool_pkg::idx_t         map_rd_addr,
    output logic                   map_rd_addr_rdy,
    output logic                   map_rd_dat_vld,
    output pool_pkg::map_word_t    map_rd_dat,
    input  logic                   map_rd_dat_rdy,
    input  logic [`POOL_CORES-1:0] ofm_rd_addr_vld,
    input  pool_pkg::idx_t         ofm_rd_addr [`POOL_CORES],
    output logic [`POOL_CORES-1:0] ofm_rd_addr_rdy,
    output logic [`POOL_CORES-1:0] ofm_rd_dat_vld,
    output pool_pkg::lanes_t       ofm_rd_dat  [`POOL_CORES],
    input  logic [`POOL_CORES-1:0] ofm_rd_dat_rdy,
    output logic                   ofm_wr_rdy
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAP_DEPTH  = 32;
    localparam int FEAT_DEPTH = 512;
    // Neighbor indices per map word
    localparam int PER_WORD   = `POOL_SRAM_W / `POOL_IDX_W;

    pool_pkg::map_word_t    map_mem  [MAP_DEPTH];
    pool_pkg::lanes_t       feat_mem [FEAT_DEPTH];
    integer                 seed = 32'h5db2;

    // Map port, one read in flight
    logic                   m_busy = 1'b0;
    logic [1:0]             m_wait = '0;
    pool_pkg::idx_t         m_addr = '0;
    logic                   m_dvld = 1'b0;
    pool_pkg::map_word_t    m_dat  = '0;
    // Feature ports, one read in flight per core
    logic [`POOL_CORES-1:0] f_busy = '0;
    logic [1:0]             f_wait [`POOL_CORES] = '{default: '0};
    pool_pkg::idx_t         f_addr [`POOL_CORES] = '{default: '0};
    logic [`POOL_CORES-1:0] f_dvld = '0;
    pool_pkg::lanes_t       f_dat  [`POOL_CORES] = '{default: '0};
    logic                   wr_rdy = 1'b0;

    assign map_rd_addr_rdy = !m_busy;
    assign map_rd_dat_vld  = m_dvld;
    assign map_rd_dat      = m_dat;
    assign ofm_rd_addr_rdy = ~f_busy;
    assign ofm_rd_dat_vld  = f_dvld;
    assign ofm_rd_dat      = f_dat;
    assign ofm_wr_rdy      = wr_rdy;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_busy <= 1'b0;
            m_dvld <= 1'b0;
            f_busy <= '0;
            f_dvld <= '0;
            wr_rdy <= 1'b0;
            // Small indices keep every feature address inside the table
            for (int a = 0; a < MAP_DEPTH; a++) begin
                for (int e = 0; e < PER_WORD; e++) begin
                    map_mem[a][e*`POOL_IDX_W +: `POOL_IDX_W] =
                        pool_pkg::idx_t'($random(seed) & 63);
                end
            end
            for (int a = 0; a < FEAT_DEPTH; a++) begin
                feat_mem[a] = pool_pkg::lanes_t'($random(seed));
            end
        end else begin
            // Ready about three cycles in four
            wr_rdy <= (($random(seed) & 3) != 0);

            // Map read, 0 to 3 extra cycles before the beat
            if (m_dvld && map_rd_dat_rdy) begin
                m_dvld <= 1'b0;
                m_busy <= 1'b0;
            end else if (map_rd_addr_vld && !m_busy) begin
                m_busy <= 1'b1;
                m_addr <= map_rd_addr;
                m_wait <= 2'($random(seed));
            end else if (m_busy && !m_dvld) begin
                if (m_wait == 2'd0) begin
                    m_dvld <= 1'b1;
                    m_dat  <= map_mem[m_addr];
                end else begin
                    m_wait <= m_wait - 1'b1;
                end
            end

            // Feature reads, same scheme per core
            for (int c = 0; c < `POOL_CORES; c++) begin
                if (f_dvld[c] && ofm_rd_dat_rdy[c]) begin
                    f_dvld[c] <= 1'b0;
                    f_busy[c] <= 1'b0;
                end else if (ofm_rd_addr_vld[c] && !f_busy[c]) begin
                    f_busy[c] <= 1'b1;
                    f_addr[c] <= ofm_rd_addr[c];
                    f_wait[c] <= 2'($random(seed));
                end else if (f_busy[c] && !f_dvld[c]) begin
                    if (f_wait[c] == 2'd0) begin
                        f_dvld[c] <= 1'b1;
                        f_dat[c]  <= feat_mem[f_addr[c]];
                    end else begin
                        f_wait[c] <= f_wait[c] - 1'b1;
                    end
                end
            end
        end
    end
endmodule

//--- rtl/pool_top.sv
// ==============================
// Pooling engine top
// Cores, map-read arbiter and write arbiter
// ==============================
`include "pool_settings.svh"

module pool_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // Per-core configuration
    input  logic [`POOL_CORES-1:0] cfg_vld,
    input  pool_pkg::idx_t         cfg_points   [`POOL_CORES],
    input  pool_pkg::nbr_t         cfg_k        [`POOL_CORES],
    input  pool_pkg::chn_t         cfg_chn      [`POOL_CORES],
    input  pool_pkg::idx_t         cfg_out_base [`POOL_CORES],
    output logic [`POOL_CORES-1:0] cfg_rdy,
    // Shared map read
    output logic                   map_rd_addr_vld,
    output pool_pkg::idx_t         map_rd_addr,
    input  logic                   map_rd_addr_rdy,
    input  logic                   map_rd_dat_vld,
    input  pool_pkg::map_word_t    map_rd_dat,
    output logic                   map_rd_dat_rdy,
    // Per-core feature read
    output logic [`POOL_CORES-1:0] ofm_rd_addr_vld,
    output pool_pkg::idx_t         ofm_rd_addr [`POOL_CORES],
    input  logic [`POOL_CORES-1:0] ofm_rd_addr_rdy,
    input  logic [`POOL_CORES-1:0] ofm_rd_dat_vld,
    input  pool_pkg::lanes_t       ofm_rd_dat  [`POOL_CORES],
    output logic [`POOL_CORES-1:0] ofm_rd_dat_rdy,
    // Shared result write
    output logic                   ofm_wr_vld,
    output pool_pkg::idx_t         ofm_wr_addr,
    output pool_pkg::lanes_t       ofm_wr_dat,
    input  logic                   ofm_wr_rdy
);
    logic [`POOL_CORES-1:0] map_req_vld;
    logic [`POOL_CORES-1:0] map_req_rdy;
    logic [`POOL_CORES-1:0] map_dat_vld;
    logic [`POOL_CORES-1:0] map_dat_rdy;
    pool_pkg::rd_req_t      map_req [`POOL_CORES];
    pool_pkg::rd_req_t      map_out;
    pool_pkg::core_sel_t    map_grant;
    logic [`POOL_CORES-1:0] wr_vld;
    logic [`POOL_CORES-1:0] wr_rdy;
    pool_pkg::wr_req_t      wr_req [`POOL_CORES];
    pool_pkg::wr_req_t      wr_out;

    // Return beat goes to the core holding the map grant
    assign map_rd_addr    = map_out.addr;
    assign map_rd_dat_rdy = map_dat_rdy[map_grant];
    assign ofm_wr_addr    = wr_out.addr;
    assign ofm_wr_dat     = wr_out.dat;

    for (genvar i = 0; i < `POOL_CORES; i++) begin : g_core
        assign map_dat_vld[i] = map_rd_dat_vld && (map_grant == pool_pkg::core_sel_t'(i));

        pool_core core_i (
            .clk             (clk),
            .rst_n           (rst_n),
            .cfg_vld         (cfg_vld[i]),
            .cfg_points      (cfg_points[i]),
            .cfg_k           (cfg_k[i]),
            .cfg_chn         (cfg_chn[i]),
            .cfg_out_base    (cfg_out_base[i]),
            .cfg_rdy         (cfg_rdy[i]),
            .map_req_vld     (map_req_vld[i]),
            .map_req         (map_req[i]),
            .map_req_rdy     (map_req_rdy[i]),
            .map_dat_vld     (map_dat_vld[i]),
            .map_dat         (map_rd_dat),
            .map_dat_rdy     (map_dat_rdy[i]),
            .ofm_rd_addr_vld (ofm_rd_addr_vld[i]),
            .ofm_rd_addr     (ofm_rd_addr[i]),
            .ofm_rd_addr_rdy (ofm_rd_addr_rdy[i]),
            .ofm_rd_dat_vld  (ofm_rd_dat_vld[i]),
            .ofm_rd_dat      (ofm_rd_dat[i]),
            .ofm_rd_dat_rdy  (ofm_rd_dat_rdy[i]),
            .wr_vld          (wr_vld[i]),
            .wr_req          (wr_req[i]),
            .wr_rdy          (wr_rdy[i])
        );
    end

    // Map grant held until the return beat is taken
    pool_arbiter #(
        .N     (`POOL_CORES),
        .req_t (pool_pkg::rd_req_t)
    ) map_arb_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (map_req_vld),
        .req     (map_req),
        .req_rdy (map_req_rdy),
        .out_vld (map_rd_addr_vld),
        .out     (map_out),
        .out_rdy (map_rd_addr_rdy),
        .done    (map_rd_dat_vld && map_rd_dat_rdy),
        .grant   (map_grant)
    );

    // Each write closes on its own handshake
    pool_arbiter #(
        .N     (`POOL_CORES),
        .req_t (pool_pkg::wr_req_t)
    ) wr_arb_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (wr_vld),
        .req     (wr_req),
        .req_rdy (wr_rdy),
        .out_vld (ofm_wr_vld),
        .out     (wr_out),
        .out_rdy (ofm_wr_rdy),
        .done    (1'b1),
        .grant   ()
    );
endmodule

//--- rtl/pool_core.sv
// ==============================
// Pooling core
// Map fetch, neighbor and group loops, max and write stage
// ==============================
`include "pool_settings.svh"

module pool_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_vld,
    input  pool_pkg::idx_t      cfg_points,
    input  pool_pkg::nbr_t      cfg_k,
    input  pool_pkg::chn_t      cfg_chn,
    input  pool_pkg::idx_t      cfg_out_base,
    output logic                cfg_rdy,
    output logic                map_req_vld,
    output pool_pkg::rd_req_t   map_req,
    input  logic                map_req_rdy,
    input  logic                map_dat_vld,
    input  pool_pkg::map_word_t map_dat,
    output logic                map_dat_rdy,
    output logic                ofm_rd_addr_vld,
    output pool_pkg::idx_t      ofm_rd_addr,
    input  logic                ofm_rd_addr_rdy,
    input  logic                ofm_rd_dat_vld,
    input  pool_pkg::lanes_t    ofm_rd_dat,
    output logic                ofm_rd_dat_rdy,
    output logic                wr_vld,
    output pool_pkg::wr_req_t   wr_req,
    input  logic                wr_rdy
);
    localparam int MW_W = $clog2(`POOL_MAP_WORDS);

    typedef enum logic [1:0] {
        IDLE,
        MAPIN,
        WAITFNH
    } state_t;

    state_t                 state;
    pool_pkg::idx_t         pts_q;
    pool_pkg::nbr_t         k_q;
    pool_pkg::chn_t         grp_q;
    pool_pkg::idx_t         base_q;
    pool_pkg::idx_t         mpt;
    logic [MW_W-1:0]        mword;
    logic                   map_pend;
    logic                   sipo_vld;
    pool_pkg::nbr_list_t    sipo_list;
    logic                   lst_load;
    logic                   lst_vld;
    pool_pkg::nbr_list_t    lst_q;
    pool_pkg::idx_t         fpt;
    pool_pkg::nbr_t         n_cnt;
    pool_pkg::chn_t         g_cnt;
    logic                   rd_pend;
    logic                   md_first;
    logic                   md_last_n;
    logic                   md_last_pt;
    pool_pkg::idx_t         md_waddr;
    pool_pkg::idx_t         wr_addr_q;
    logic                   wr_last_q;
    pool_pkg::lanes_t       max_dat;
    logic                   cfg_hs;
    logic                   mreq_hs;
    logic                   rda_hs;
    logic                   rdd_hs;
    logic                   wr_hs;
    logic                   last_word;
    logic                   last_n;
    logic                   last_g;

    assign cfg_rdy  = (state == IDLE);
    assign cfg_hs   = cfg_vld && cfg_rdy;
    assign mreq_hs  = map_req_vld && map_req_rdy;
    assign rda_hs   = ofm_rd_addr_vld && ofm_rd_addr_rdy;
    assign rdd_hs   = ofm_rd_dat_vld && ofm_rd_dat_rdy;
    assign wr_hs    = wr_vld && wr_rdy;

    // ==============================
    // Map fetch, one word in flight
    // ==============================
    assign last_word    = (mword == MW_W'(`POOL_MAP_WORDS - 1));
    assign map_req_vld  = (state == MAPIN) && !map_pend;
    assign map_req.addr = pool_pkg::idx_t'(mpt * `POOL_MAP_WORDS + mword);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            mpt      <= '0;
            mword    <= '0;
            map_pend <= 1'b0;
        end else begin
            case (state)
                IDLE:    if (cfg_hs) state <= MAPIN;
                MAPIN:   if (mreq_hs && last_word && (mpt == pts_q - 1'b1)) state <= WAITFNH;
                WAITFNH: if (wr_hs && wr_last_q) state <= IDLE;
                default: state <= IDLE;
            endcase
            if (cfg_hs) begin
                mpt   <= '0;
                mword <= '0;
            end else if (mreq_hs) begin
                mword <= last_word ? '0 : mword + 1'b1;
                if (last_word) begin
                    mpt <= mpt + 1'b1;
                end
            end
            if (mreq_hs) begin
                map_pend <= 1'b1;
            end else if (map_dat_vld && map_dat_rdy) begin
                map_pend <= 1'b0;
            end
        end
    end

    // Held for the whole run
    always_ff @(posedge clk) begin
        if (cfg_hs) begin
            pts_q  <= cfg_points;
            k_q    <= cfg_k;
            grp_q  <= pool_pkg::chn_t'(cfg_chn / `POOL_LANES);
            base_q <= cfg_out_base;
        end
    end

    map_sipo sipo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_vld   (map_dat_vld),
        .in_dat   (map_dat),
        .in_rdy   (map_dat_rdy),
        .out_vld  (sipo_vld),
        .out_list (sipo_list),
        .out_rdy  (!lst_vld)
    );

    // ==============================
    // Neighbor and group loops
    // ==============================
    // Local copy frees the sipo for the next point
    assign lst_load        = sipo_vld && !lst_vld;
    assign last_n          = (n_cnt == k_q - 1'b1);
    assign last_g          = (g_cnt == grp_q - 1'b1);
    // One feature read outstanding
    assign ofm_rd_addr_vld = lst_vld && !rd_pend;
    assign ofm_rd_addr     = pool_pkg::idx_t'(grp_q) * lst_q[n_cnt[`POOL_NBR_W-1:0]]
                             + pool_pkg::idx_t'(g_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lst_vld <= 1'b0;
            fpt     <= '0;
            n_cnt   <= '0;
            g_cnt   <= '0;
            rd_pend <= 1'b0;
        end else begin
            if (cfg_hs) begin
                fpt <= '0;
            end
            if (lst_load) begin
                lst_vld <= 1'b1;
            end else if (rda_hs && last_n && last_g) begin
                lst_vld <= 1'b0;
            end
            // Neighbors inner, channel groups outer
            if (rda_hs) begin
                n_cnt <= last_n ? '0 : n_cnt + 1'b1;
                if (last_n) begin
                    g_cnt <= last_g ? '0 : g_cnt + 1'b1;
                    if (last_g) begin
                        fpt <= fpt + 1'b1;
                    end
                end
            end
            if (rda_hs) begin
                rd_pend <= 1'b1;
            end else if (rdd_hs) begin
                rd_pend <= 1'b0;
            end
        end
    end

    // Stage tags follow the read into the max stage
    always_ff @(posedge clk) begin
        if (lst_load) begin
            lst_q <= sipo_list;
        end
        if (rda_hs) begin
            md_first   <= (n_cnt == '0);
            md_last_n  <= last_n;
            md_last_pt <= last_n && last_g && (fpt == pts_q - 1'b1);
            md_waddr   <= base_q + fpt * pool_pkg::idx_t'(grp_q) + pool_pkg::idx_t'(g_cnt);
        end
        if (rdd_hs && md_last_n) begin
            wr_addr_q <= md_waddr;
            wr_last_q <= md_last_pt;
        end
    end

    // ==============================
    // Max and write
    // ==============================
    // Held result blocks the next feature beat
    assign ofm_rd_dat_rdy = !wr_vld || wr_rdy;

    pool_max_unit max_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vld  (rdd_hs),
        .first   (md_first),
        .in_dat  (ofm_rd_dat),
        .max_dat (max_dat)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_vld <= 1'b0;
        end else if (rdd_hs && md_last_n) begin
            wr_vld <= 1'b1;
        end else if (wr_hs) begin
            wr_vld <= 1'b0;
        end
    end

    assign wr_req = '{addr: wr_addr_q, dat: max_dat};
endmodule

//--- rtl/pool_max_unit.sv
// ==============================
// Lane-wise max unit
// Running unsigned maximum over the neighbors of one group
// ==============================
`include "pool_settings.svh"

module pool_max_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_vld,
    input  logic             first,
    input  pool_pkg::lanes_t in_dat,
    output pool_pkg::lanes_t max_dat
);
    // Result ready the cycle after the K-th feature beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            max_dat <= '0;
        end else if (in_vld) begin
            for (int l = 0; l < `POOL_LANES; l++) begin
                // First neighbor loads, later ones compare
                if (first || (in_dat[l] > max_dat[l])) begin
                    max_dat[l] <= in_dat[l];
                end
            end
        end
    end
endmodule

//--- rtl/map_sipo.sv
// ==============================
// Map deserializer
// Gathers map words into one neighbor list per point
// ==============================
`include "pool_settings.svh"

module map_sipo (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_vld,
    input  pool_pkg::map_word_t in_dat,
    output logic                in_rdy,
    output logic                out_vld,
    output pool_pkg::nbr_list_t out_list,
    input  logic                out_rdy
);
    localparam int CNT_W = $clog2(`POOL_MAP_WORDS + 1);

    // Words collected so far for the current list
    logic [CNT_W-1:0]                               cnt;
    pool_pkg::map_word_t [`POOL_MAP_WORDS-1:0]      shreg;

    // Full once the last word is in
    assign out_vld = (cnt == CNT_W'(`POOL_MAP_WORDS));
    // Stall the map return while a full list waits
    assign in_rdy  = !out_vld;
    // First word ends up in the low bits
    assign out_list = shreg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (out_vld && out_rdy) begin
            cnt <= '0;
        end else if (in_vld && in_rdy) begin
            cnt <= cnt + 1'b1;
        end
    end

    // New word enters at the top and moves down
    always_ff @(posedge clk) begin
        if (in_vld && in_rdy) begin
            shreg <= {in_dat, shreg[`POOL_MAP_WORDS-1:1]};
        end
    end
endmodule

//--- rtl/pool_arbiter.sv
// ==============================
// Round-robin request arbiter
// Merges per-core valid/payload into one port
// Grant held until the transfer closes
// ==============================
`include "pool_settings.svh"

module pool_arbiter #(
    parameter int  N     = `POOL_CORES,
    parameter type req_t = pool_pkg::rd_req_t
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [N-1:0]        req_vld,
    input  req_t                req [N],
    output logic [N-1:0]        req_rdy,
    output logic                out_vld,
    output req_t                out,
    input  logic                out_rdy,
    input  logic                done,
    output pool_pkg::core_sel_t grant
);
    pool_pkg::core_sel_t last;
    pool_pkg::core_sel_t pick;
    logic                found;
    // Accepted request waiting for its closing beat
    logic                busy;

    // Search starts one past the last winner
    always_comb begin
        pick  = last;
        found = 1'b0;
        for (int k = 1; k <= N; k++) begin
            if (!found && req_vld[(int'(last) + k) % N]) begin
                pick  = pool_pkg::core_sel_t'((int'(last) + k) % N);
                found = 1'b1;
            end
        end
    end

    // Held winner while busy, else the fresh pick
    assign grant   = busy ? last : pick;
    assign out_vld = !busy && req_vld[grant];
    assign out     = req[grant];

    always_comb begin
        req_rdy        = '0;
        req_rdy[grant] = !busy && out_rdy;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // First search then starts at core 0
            last <= pool_pkg::core_sel_t'(N - 1);
            busy <= 1'b0;
        end else begin
            if (out_vld && out_rdy) begin
                last <= grant;
            end
            // Write port closes on its own handshake, done tied high
            if (out_vld && out_rdy && !done) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end
endmodule

//--- rtl/pool_pkg.sv
// ==============================
// Pooling engine types
// Index, lane, map and request types
// ==============================
`include "pool_settings.svh"

package pool_pkg;
    // Buffer address or neighbor index
    typedef logic [`POOL_IDX_W-1:0] idx_t;
    // One spare bit so that K can cover the whole list
    typedef logic [`POOL_NBR_W:0] nbr_t;
    typedef logic [`POOL_CHN_W-1:0] chn_t;
    typedef logic [`POOL_ACT_W-1:0] act_t;
    // Feature word, lane 0 in the low bits
    typedef act_t [`POOL_LANES-1:0] lanes_t;
    typedef logic [`POOL_SRAM_W-1:0] map_word_t;
    // Neighbor list, entry 0 in the low bits of the first map word
    typedef idx_t [(1 << `POOL_NBR_W)-1:0] nbr_list_t;
    typedef logic [$clog2(`POOL_CORES)-1:0] core_sel_t;
    typedef struct packed {
        idx_t addr;
    } rd_req_t;
    typedef struct packed {
        idx_t   addr;
        lanes_t dat;
    } wr_req_t;
endpackage

//--- rtl/pool_settings.svh
// ==============================
// Pooling engine sizes
// Core count, lane count, field widths and map geometry
// ==============================
`ifndef POOL_SETTINGS_SVH
`define POOL_SETTINGS_SVH

// Pooling cores sharing the map and write ports
`define POOL_CORES 2
// Channels compared in parallel
`define POOL_LANES 4
// Bits per activation
`define POOL_ACT_W 8
// Buffer address and neighbor index
`define POOL_IDX_W 16
// Map list holds 2**POOL_NBR_W neighbor indices
`define POOL_NBR_W 3
// Global buffer map word
`define POOL_SRAM_W 64
// Map words per output point, 8 x 16 / 64
`define POOL_MAP_WORDS 2
// Channel count field
`define POOL_CHN_W 8

`endif
